/* logic/routePkg.sv */
`default_nettype none

package routePkg;

	////////////////////////////////////////
	// Widths and depths
	////////////////////////////////////////
	localparam int dataW     = 4;                   // Nibble
	localparam int laneCount = 4;                   // Lane accumulators
	localparam int laneW     = $clog2(laneCount);   // Lane select, 2 bits
	localparam int fifoDepth = 8;                   // Entries per FIFO
	localparam int ptrW      = $clog2(fifoDepth);   // Pointer, wraps at depth
	localparam int countW    = ptrW + 1;            // Holds 0 up to fifoDepth

	// Occupancy at which a FIFO reports full
	localparam logic [countW-1:0] fullCount = countW'(fifoDepth);

	////////////////////////////////////////
	// Packed words
	////////////////////////////////////////

	// Select field, one per written nibble
	typedef struct packed {
		logic [laneW-1:0] laneSel;    // Lane to update
		logic             reverseEn;  // Bit-reverse the result
	} routeSel_t;

	// Input FIFO entry, 7 bits
	typedef struct packed {
		logic [dataW-1:0] data;
		routeSel_t        sel;
	} inWord_t;

	// Output FIFO entry, 6 bits
	typedef struct packed {
		logic [laneW-1:0] lane;  // Tag, copy of laneSel
		logic [dataW-1:0] data;  // Accumulator value, maybe reversed
	} outWord_t;

endpackage

`default_nettype wire

/* logic/syncFifo.sv */
`default_nettype none

// Circular buffer with strobe push and strobe pop
module syncFifo #(
	parameter type payload_t = logic
) (
	input  logic     inClock,
	input  logic     rstN,
	input  logic     push,       // Dropped when full
	input  payload_t pushWord,
	input  logic     pop,        // Ignored when empty
	output payload_t readWord,   // Popped entry one cycle later
	output logic     readValid,
	output payload_t headWord,   // Oldest entry always visible
	output logic     empty,
	output logic     full
);

	payload_t                    mem [routePkg::fifoDepth];
	logic [routePkg::ptrW-1:0]   wrPtr;
	logic [routePkg::ptrW-1:0]   rdPtr;
	logic [routePkg::countW-1:0] count;  // Occupancy
	logic                        doPush;
	logic                        doPop;

	////////////////////////////////////////
	// Flags and qualified strobes
	////////////////////////////////////////
	assign empty    = (count == '0);
	assign full     = (count == routePkg::fullCount);
	assign doPush   = push && !full;
	assign doPop    = pop && !empty;
	assign headWord = mem[rdPtr];

	////////////////////////////////////////
	// Pointers, count, valid
	////////////////////////////////////////
	always_ff @(posedge inClock) begin
		if (!rstN) begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			count     <= '0;
			readValid <= 1'b0;
		end else begin
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1;  // Wraps since depth is a power of two
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
			readValid <= doPop;  // High one cycle only
		end
	end

	// Storage and read register
	always_ff @(posedge inClock) begin
		if (doPush) begin
			mem[wrPtr] <= pushWord;
		end
		if (doPop) begin
			readWord <= mem[rdPtr];
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////
	assert property (@(posedge inClock) disable iff (!rstN)
		count <= routePkg::fullCount);

	// Pop of an empty FIFO yields nothing
	assert property (@(posedge inClock) disable iff (!rstN)
		(pop && empty) |=> !readValid);

endmodule

`default_nettype wire

/* logic/laneRouter.sv */
`default_nettype none

// Drains the input FIFO into four XOR lane accumulators
module laneRouter (
	input  logic               inClock,
	input  logic               rstN,
	input  logic               srcEmpty,  // Input FIFO empty
	input  routePkg::inWord_t  srcWord,   // Popped entry
	input  logic               srcValid,  // srcWord holds a popped entry
	output logic               srcPop,
	input  logic               dstFull,   // Output FIFO full
	output logic               dstPush,
	output routePkg::outWord_t dstWord
);

	logic [routePkg::dataW-1:0] accum [routePkg::laneCount];
	logic                       pending;  // Pop issued and entry not yet here
	logic [routePkg::dataW-1:0] newVal;
	logic [routePkg::dataW-1:0] revVal;

	////////////////////////////////////////
	// Pop decision
	////////////////////////////////////////

	// Room check counts the in-flight entry.
	// With one pending, the output FIFO
	// might fill on its push, so hold off.
	assign srcPop = !srcEmpty && !dstFull && !pending;

	always_ff @(posedge inClock) begin
		if (!rstN) begin
			pending <= 1'b0;
		end else begin
			pending <= srcPop;  // Entry lands next cycle
		end
	end

	////////////////////////////////////////
	// Accumulate and transform
	////////////////////////////////////////
	assign newVal = accum[srcWord.sel.laneSel] ^ srcWord.data;

	// Bit reversal of the new value
	always_comb begin
		for (int i = 0; i < routePkg::dataW; i++) begin
			revVal[i] = newVal[routePkg::dataW-1-i];
		end
	end

	// Lanes keep the plain value and reversal is on the way out only
	always_ff @(posedge inClock) begin
		if (!rstN) begin
			for (int i = 0; i < routePkg::laneCount; i++) begin
				accum[i] <= '0;
			end
		end else if (srcValid) begin
			accum[srcWord.sel.laneSel] <= newVal;
		end
	end

	////////////////////////////////////////
	// Push to output FIFO
	////////////////////////////////////////
	assign dstPush = srcValid;  // Same edge as the lane update
	assign dstWord = '{
		lane: srcWord.sel.laneSel,                         // Tag
		data: srcWord.sel.reverseEn ? revVal : newVal
	};

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Flow control keeps the output FIFO from overflowing
	assert property (@(posedge inClock) disable iff (!rstN)
		dstPush |-> !dstFull);

endmodule

`default_nettype wire

/* logic/routeTop.sv */
`default_nettype none

// Writer -> inFifo -> laneRouter -> outFifo -> reader
module routeTop (
	input  logic                       inClock,
	input  logic                       rstN,
	input  logic                       inWrite,     // Write strobe
	input  logic [routePkg::dataW-1:0] inData,
	input  routePkg::routeSel_t        inSel,
	input  logic                       readEnable,  // Read strobe
	output routePkg::outWord_t         outWord,
	output logic                       outValid,    // One cycle after readEnable
	output logic                       inFull
);

	routePkg::inWord_t  inEntry;   // Packed write
	routePkg::inWord_t  srcWord;
	logic               srcEmpty;
	logic               srcValid;
	logic               srcPop;
	logic               dstFull;
	logic               dstPush;
	routePkg::outWord_t dstWord;

	assign inEntry = '{data: inData, sel: inSel};

	////////////////////////////////////////
	// Input side
	////////////////////////////////////////
	syncFifo #(
		.payload_t (routePkg::inWord_t)
	) inFifo (
		.inClock   (inClock),
		.rstN      (rstN),
		.push      (inWrite),
		.pushWord  (inEntry),
		.pop       (srcPop),
		.readWord  (srcWord),
		.readValid (srcValid),
		.headWord  (),
		.empty     (srcEmpty),
		.full      (inFull)     // Writes while full are dropped
	);

	laneRouter router (
		.inClock  (inClock),
		.rstN     (rstN),
		.srcEmpty (srcEmpty),
		.srcWord  (srcWord),
		.srcValid (srcValid),
		.srcPop   (srcPop),
		.dstFull  (dstFull),
		.dstPush  (dstPush),
		.dstWord  (dstWord)
	);

	////////////////////////////////////////
	// Output side
	////////////////////////////////////////
	syncFifo #(
		.payload_t (routePkg::outWord_t)
	) outFifo (
		.inClock   (inClock),
		.rstN      (rstN),
		.push      (dstPush),
		.pushWord  (dstWord),
		.pop       (readEnable),  // Empty reads ignored
		.readWord  (outWord),
		.readValid (outValid),
		.headWord  (),
		.empty     (),
		.full      (dstFull)
	);

endmodule

`default_nettype wire

/* verification/routeChecker.sv */
`default_nettype none

// Watches the DUT ports and compares against a model of the routing rules
module routeChecker (
	input  logic                       inClock,
	input  logic                       rstN,
	input  logic                       inWrite,
	input  logic [routePkg::dataW-1:0] inData,
	input  routePkg::routeSel_t        inSel,
	input  logic                       readEnable,
	input  routePkg::outWord_t         outWord,
	input  logic                       outValid,
	input  logic                       inFull,
	input  logic                       runDone,       // Stimulus finished
	output int                         mismatchCount,
	output int                         otherErrors
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [routePkg::dataW-1:0] laneAcc [routePkg::laneCount];  // Model lanes
	routePkg::outWord_t         expQ [$];                        // Words not yet read
	routePkg::outWord_t         expWord;
	logic [routePkg::dataW-1:0] nextVal;
	logic                       prevRead;  // readEnable at the previous edge
	bit                         sawFull;
	bit                         doneSeen;

	// MSB of the result is bit 0 of the input
	function automatic logic [routePkg::dataW-1:0] reverseBits(
		input logic [routePkg::dataW-1:0] v
	);
		logic [routePkg::dataW-1:0] r;
		r = '0;
		for (int i = 0; i < routePkg::dataW; i++) begin
			r = {r[routePkg::dataW-2:0], v[i]};  // Shift in from the low end
		end
		return r;
	endfunction

	////////////////////////////////////////
	// Model and compare, once per edge
	////////////////////////////////////////
	always @(posedge inClock) begin
		if (!rstN) begin
			for (int i = 0; i < routePkg::laneCount; i++) begin
				laneAcc[i] = '0;
			end
			expQ.delete();
			prevRead = 1'b0;
		end else begin
			// Read side first, a word leaves before new ones arrive
			if (outValid) begin
				if (!prevRead) begin
					$display("outValid rose without a readEnable the cycle before");
					otherErrors++;
				end
				if (expQ.size() == 0) begin
					$display("outValid with no expected word outstanding");
					otherErrors++;
				end else begin
					expWord = expQ.pop_front();
					if (outWord.lane !== expWord.lane) begin
						$display("Mismatch outWord.lane: expected 0x%h, got 0x%h",
							expWord.lane, outWord.lane);
						mismatchCount++;
					end
					if (outWord.data !== expWord.data) begin
						$display("Mismatch outWord.data: expected 0x%h, got 0x%h",
							expWord.data, outWord.data);
						mismatchCount++;
					end
				end
			end
			// Input FIFO can only be full with a whole FIFO's worth outstanding
			if (inFull) begin
				sawFull = 1'b1;
				if (expQ.size() < routePkg::fifoDepth) begin
					$display("inFull high with only %0d words outstanding", expQ.size());
					otherErrors++;
				end
			end
			// Accepted write: XOR into its lane, tag, maybe reverse
			if (inWrite && !inFull) begin
				nextVal = laneAcc[inSel.laneSel] ^ inData;
				laneAcc[inSel.laneSel] = nextVal;  // Plain value kept
				expWord.lane = inSel.laneSel;
				expWord.data = inSel.reverseEn ? reverseBits(nextVal) : nextVal;
				expQ.push_back(expWord);
			end
			prevRead = readEnable;
			// End of run checks, once
			if (runDone && !doneSeen) begin
				doneSeen = 1'b1;
				if (expQ.size() != 0) begin
					$display("%0d expected words were never read out", expQ.size());
					otherErrors++;
				end
				if (!sawFull) begin
					$display("inFull never rose during the write burst");
					otherErrors++;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verification/tbRouteTop.sv */
`default_nettype none

// Reads the stimulus file and strobes the routing top level
module tbRouteTop;

	timeunit 1ns;
	timeprecision 100ps;

	logic                       inClock;
	logic                       rstN;
	logic                       inWrite;
	logic [routePkg::dataW-1:0] inData;
	routePkg::routeSel_t        inSel;
	logic                       readEnable;
	routePkg::outWord_t         outWord;
	logic                       outValid;
	logic                       inFull;
	logic                       runDone;
	int                         mismatchCount;
	int                         otherErrors;
	int                         fileErrors;
	int                         watchdogCycles;
	int                         totalErrors;

	// Parsed commands, one entry each
	logic [7:0]                 cmdKind [$];
	logic [routePkg::dataW-1:0] cmdData [$];
	logic [2:0]                 cmdSel [$];
	int                         cmdCount [$];

	routeTop dut (
		.inClock    (inClock),
		.rstN       (rstN),
		.inWrite    (inWrite),
		.inData     (inData),
		.inSel      (inSel),
		.readEnable (readEnable),
		.outWord    (outWord),
		.outValid   (outValid),
		.inFull     (inFull)
	);

	routeChecker scoreboard (
		.inClock       (inClock),
		.rstN          (rstN),
		.inWrite       (inWrite),
		.inData        (inData),
		.inSel         (inSel),
		.readEnable    (readEnable),
		.outWord       (outWord),
		.outValid      (outValid),
		.inFull        (inFull),
		.runDone       (runDone),
		.mismatchCount (mismatchCount),
		.otherErrors   (otherErrors)
	);

	initial begin
		inClock = 1'b0;
		forever #20 inClock = ~inClock;  // 40 ns period
	end

	////////////////////////////////////////
	// Stimulus file
	////////////////////////////////////////
	task loadStimulus;
		int                         fd;
		int                         code;
		logic [7:0]                 kind;
		logic [routePkg::dataW-1:0] d;
		logic [2:0]                 s;
		int                         n;
		logic [1023:0]              rest;
		bit                         done;
		fd = $fopen("verification/routeStimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open verification/routeStimulus.txt");
			fileErrors++;
		end else begin
			done = 1'b0;
			while (!done) begin
				code = $fscanf(fd, " %c", kind);
				if (code != 1) begin
					done = 1'b1;  // End of file
				end else begin
					case (kind)
						"#": code = $fgets(rest, fd);  // Comment, skip the line
						"W": begin
							code = $fscanf(fd, " %h %h", d, s);
							cmdKind.push_back(kind);
							cmdData.push_back(d);
							cmdSel.push_back(s);
							cmdCount.push_back(1);
							if (code != 2) begin
								$display("Write line in the stimulus file lacks data or sel");
								fileErrors++;
							end
						end
						"R": begin
							cmdKind.push_back(kind);
							cmdData.push_back('0);
							cmdSel.push_back('0);
							cmdCount.push_back(1);
						end
						"I": begin
							code = $fscanf(fd, " %d", n);
							cmdKind.push_back(kind);
							cmdData.push_back('0);
							cmdSel.push_back('0);
							cmdCount.push_back(n);
						end
						default: begin
							$display("Unknown command '%c' in the stimulus file", kind);
							fileErrors++;
							done = 1'b1;
						end
					endcase
				end
			end
			$fclose(fd);
		end
	endtask

	// Each command plus the largest idle gap, reset, drain and margin
	function int estimateCycles();
		int cycles;
		cycles = 2 + 6 + 200;
		for (int k = 0; k < cmdKind.size(); k++) begin
			cycles += cmdCount[k] + 3;
		end
		return cycles;
	endfunction

	////////////////////////////////////////
	// Driver
	////////////////////////////////////////
	task driveCycle(
		input logic                       w,
		input logic                       r,
		input logic [routePkg::dataW-1:0] d,
		input routePkg::routeSel_t        s
	);
		@(posedge inClock);
		inWrite    <= w;
		readEnable <= r;
		inData     <= d;
		inSel      <= s;
	endtask

	task runCommand(input int k);
		int gap;
		gap = $urandom_range(3, 0);  // Random idle cycles first
		repeat (gap) driveCycle(1'b0, 1'b0, '0, '0);
		case (cmdKind[k])
			"W":     driveCycle(1'b1, 1'b0, cmdData[k], routePkg::routeSel_t'(cmdSel[k]));
			"R":     driveCycle(1'b0, 1'b1, '0, '0);
			default: repeat (cmdCount[k]) driveCycle(1'b0, 1'b0, '0, '0);
		endcase
	endtask

	initial begin
		void'($urandom(32'hd554));
		rstN       = 1'b0;
		inWrite    = 1'b0;
		inData     = '0;
		inSel      = '0;
		readEnable = 1'b0;
		runDone    = 1'b0;
		loadStimulus();
		watchdogCycles = estimateCycles();
		repeat (2) @(posedge inClock);
		rstN <= 1'b1;
		for (int k = 0; k < cmdKind.size(); k++) begin
			runCommand(k);
		end
		repeat (4) driveCycle(1'b0, 1'b0, '0, '0);  // Last outValid lands
		runDone <= 1'b1;
		repeat (2) @(posedge inClock);
		totalErrors = mismatchCount + otherErrors + fileErrors;
		$display("Errors: %0d mismatches, %0d other, %0d stimulus",
			mismatchCount, otherErrors, fileErrors);
		if (totalErrors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Watchdog, armed once the command list is known
	initial begin
		wait (watchdogCycles > 0);
		repeat (watchdogCycles) @(posedge inClock);
		$display("Timeout: run did not finish within %0d cycles", watchdogCycles);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/routeStimulus.txt */
# Columns: W data sel | R | I count   (data and sel in hex, count in decimal)
# sel is {laneSel[1:0], reverseEn}; R strobes readEnable; I idles count cycles
# Reads right after reset, output FIFO still empty
R
R
I 3
# Lane 0 running XOR, plain output
W 3 0
W 5 0
W 9 0
W 6 0
# All four lanes interleaved, some reversed
W 1 2
W 2 4
W 4 6
W 8 3
W a 0
W c 7
W 7 5
W e 2
# No reads yet, so this burst fills both FIFOs
W 1 0
W f 6
W 3 3
W 5 4
W 9 1
W b 2
I 6
W 4 6
W d 0
# Drain, the last reads find the output FIFO empty
R
R
R
R
R
R
R
R
R
R
R
R
R
R
R
R
R
R
I 4

/* build.f */
logic/routePkg.sv
logic/syncFifo.sv
logic/laneRouter.sv
logic/routeTop.sv
verification/routeChecker.sv
verification/tbRouteTop.sv

/* runSim.sh */
#!/bin/sh
# Compile and run the routing testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tbRouteTop -Mdir obj_dir -f build.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/VtbRouteTop)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^ALL CHECKS PASSED$"; then
	exit 0
fi
exit 1
